// File: Makefile
# Verilator build and run for the PCS receive synchronizer testbench.

VERILATOR ?= verilator
TOP       ?= tb_pcs_sync
FLAGS     ?= --binary --timing --assert
FILELIST  ?= tb.f

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// File: code_group_classifier.sv
// Input stage, one register from rx_cg to the code group bus.
// Validity is a table lookup only, so a wrong-disparity group still passes.
`timescale 1ns/1ps

module code_group_classifier (
    input  logic                      clk,
    input  logic                      reset,
    input  pcs_sync_pkg::code_group_t rx_cg,
    code_group_if.source              cg_bus
);

    logic rx_comma;     // Incoming group is a comma.
    logic rx_idle_data; // Incoming group is idle data.
    logic rx_valid;     // Incoming group is in the table.

    assign rx_comma = (rx_cg == pcs_sync_pkg::k28_5_neg) ||
                      (rx_cg == pcs_sync_pkg::k28_5_pos);

    assign rx_idle_data = (rx_cg == pcs_sync_pkg::idle_d5_6) ||
                          (rx_cg == pcs_sync_pkg::idle_d16_2_neg) ||
                          (rx_cg == pcs_sync_pkg::idle_d16_2_pos);

    // Linear search of the table.
    always_comb begin
        rx_valid = 1'b0;
        for (int i = 0; i < pcs_sync_pkg::num_valid_code_groups; i++) begin
            if (rx_cg == pcs_sync_pkg::valid_code_groups[i]) begin
                rx_valid = 1'b1; // Hit.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            cg_bus.cg           <= '0; // Keeps sudi clean right after reset.
            cg_bus.is_comma     <= 1'b0;
            cg_bus.is_idle_data <= 1'b0;
            cg_bus.is_valid     <= 1'b0;
        end else begin
            cg_bus.cg           <= rx_cg;
            cg_bus.is_comma     <= rx_comma;
            cg_bus.is_idle_data <= rx_idle_data;
            cg_bus.is_valid     <= rx_valid;
        end
    end

    // The comma constants must also sit in the valid table.
    a_comma_is_valid: assert property (
        @(posedge clk) disable iff (!reset) cg_bus.is_comma |-> cg_bus.is_valid
    ) else $error("Comma code group classified as invalid.");

endmodule

// File: code_group_if.sv
// Registered code group plus its classification flags.
// All signals are driven by the classifier on the rising edge of clk.
`timescale 1ns/1ps

interface code_group_if;

    pcs_sync_pkg::code_group_t cg; // Registered code group.
    logic is_comma;                // K28.5 of either polarity.
    logic is_idle_data;            // D5.6 or D16.2, second half of /I/.
    logic is_valid;                // Found in the valid table.

    modport source (
        output cg, is_comma, is_idle_data, is_valid
    );

    modport control (
        input is_comma, is_idle_data, is_valid
    );

    modport sink (
        input cg, is_comma
    );

endinterface

// File: pcs_sync_pkg.sv
// Shared types and constants for the 1000BASE-X receive synchronizer.
// The valid table is a fixed subset of code groups, not a full 8b/10b check.
// Running disparity is not tracked; both polarities of each group are accepted.
package pcs_sync_pkg;

    typedef logic [9:0] code_group_t; // One 10-bit code group as received.

    // SUDI word, code group in the upper ten bits.
    typedef struct packed {
        code_group_t code_group;
        logic        even;
    } sudi_t;

    // One-hot state encoding.
    typedef enum logic [5:0] {
        loss_of_sync  = 6'b000001,
        comma_detect  = 6'b000010,
        acquire_sync  = 6'b000100,
        sync_acquired = 6'b001000,
        sync_error    = 6'b010000,
        sync_recover  = 6'b100000
    } sync_state_t;

    localparam code_group_t k28_5_neg      = 10'b0011111010; // Comma, RD-.
    localparam code_group_t k28_5_pos      = 10'b1100000101; // Comma, RD+.
    localparam code_group_t idle_d5_6      = 10'b1010010110; // /I1/ second group.
    localparam code_group_t idle_d16_2_neg = 10'b0110110101; // /I2/ second group, RD-.
    localparam code_group_t idle_d16_2_pos = 10'b1001000101; // /I2/ second group, RD+.

    localparam int num_valid_code_groups = 30;

    // Accepted code groups, data first, then idle data, then specials.
    localparam code_group_t valid_code_groups [num_valid_code_groups] = '{
        10'b1101100100, 10'b0010011011, // D27.0
        10'b0011101011, 10'b0011100100, // D28.0
        10'b1011100100, 10'b0100011011, // D29.0
        10'b0111100100, 10'b1000011011, // D30.0
        10'b1010110100, 10'b0101001011, // D31.0
        10'b1001111001, 10'b0110001001, // D0.1
        10'b0111011001, 10'b1000101001, // D1.1
        10'b1011011001, 10'b0100101001, // D2.1
        10'b1100011001,                 // D3.1, same in both polarities.
        10'b1101011001, 10'b0010101001, // D4.1
        idle_d5_6,                      // D5.6
        idle_d16_2_neg, idle_d16_2_pos, // D16.2
        k28_5_neg, k28_5_pos,           // K28.5 comma.
        10'b1110101000, 10'b0001010111, // K23.7 /R/.
        10'b1101101000, 10'b0010010111, // K27.7 /S/.
        10'b1011101000, 10'b0100010111  // K29.7 /T/.
    };

    localparam int default_idle_count = 3; // Comma+idle pairs to acquire sync.
    localparam int default_good_run   = 3; // Valid groups in a row to end recovery.
    localparam int default_bad_limit  = 4; // Invalid groups that drop sync.

endpackage

// File: pcs_sync_top.sv
// Receive synchronizer top, two cycles from rx_cg to sudi.
// One code group per clock, no flow control.
`timescale 1ns/1ps

module pcs_sync_top #(
    parameter int idle_count = pcs_sync_pkg::default_idle_count,
    parameter int good_run   = pcs_sync_pkg::default_good_run,
    parameter int bad_limit  = pcs_sync_pkg::default_bad_limit
) (
    input  logic                      clk,
    input  logic                      reset,
    input  pcs_sync_pkg::code_group_t rx_cg,
    output pcs_sync_pkg::sudi_t       sudi,
    output logic                      sync_status
);

    code_group_if cg_bus (); // Classifier to FSM and formatter.

    logic sync_ok; // Next-state sync, combinational.

    code_group_classifier classifier_inst (
        .clk    (clk),
        .reset  (reset),
        .rx_cg  (rx_cg),
        .cg_bus (cg_bus)
    );

    sync_state_machine #(
        .idle_count (idle_count),
        .good_run   (good_run),
        .bad_limit  (bad_limit)
    ) fsm_inst (
        .clk     (clk),
        .reset   (reset),
        .cg_bus  (cg_bus),
        .sync_ok (sync_ok)
    );

    sudi_formatter formatter_inst (
        .clk         (clk),
        .reset       (reset),
        .cg_bus      (cg_bus),
        .sync_ok     (sync_ok),
        .sudi        (sudi),
        .sync_status (sync_status)
    );

endmodule

// File: sudi_formatter.sv
// Output stage, registers the SUDI word and sync status.
// A comma forces even to 1; every other group toggles it.
`timescale 1ns/1ps

module sudi_formatter (
    input  logic                 clk,
    input  logic                 reset,
    code_group_if.sink           cg_bus,
    input  logic                 sync_ok,
    output pcs_sync_pkg::sudi_t  sudi,
    output logic                 sync_status
);

    logic even_q;    // Flag of the last output.
    logic even_next; // Flag for the group now on the bus.

    assign even_next = cg_bus.is_comma ? 1'b1 : ~even_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            even_q      <= 1'b1; // First non-comma after reset comes out odd.
            sudi        <= '0;
            sync_status <= 1'b0;
        end else begin
            even_q          <= even_next;
            sudi.code_group <= cg_bus.cg;
            sudi.even       <= even_next;
            sync_status     <= sync_ok; // Sync after this group.
        end
    end

    // Two non-comma groups back to back must leave with opposite flags.
    a_even_alternates: assert property (
        @(posedge clk) disable iff (!reset)
        (reset && !cg_bus.is_comma) ##1 !cg_bus.is_comma
            |=> (sudi.even != $past(sudi.even))
    ) else $error("Even flag did not alternate.");

endmodule

// File: sync_cases.txt
# rx_cg  expected_sudi  expected_sync_status, all hex, one case per line.
# sudi is {code group, even}; it is checked two clocks after rx_cg is applied.
364 6c9 0   # Data while out of sync.
0eb 1d6 0
0fa 1f5 0   # Comma, then idle.
296 52c 0
0fa 1f5 0
364 6c8 0   # Comma followed by data, back to loss.
305 60b 0
1b5 36a 0
0fa 1f5 0
245 48a 0
0eb 1d7 0   # Two pairs only, then data.
0fa 1f5 0
296 52c 0
0fa 1f5 0
1b5 36a 0
305 60b 0
296 52c 1   # Third idle, sync acquired.
364 6c9 1
0eb 1d6 1
000 001 1   # Three invalid groups.
3ff 7fe 1
000 001 1
364 6c8 1   # Three valid groups, full recovery.
0eb 1d7 1
0fa 1f5 1
319 632 1
3ff 7ff 1   # Three invalid groups again.
3ff 7fe 1
000 001 1
364 6c8 1   # Valid group breaks the run.
000 001 0   # Fourth invalid, sync lost.
0fa 1f5 0   # Re-acquisition.
245 48a 0
305 60b 0
296 52c 0
0fa 1f5 0
1b5 36a 1

// File: sync_state_machine.sv
// Synchronization FSM, next state decided combinationally from the flags.
// sync_ok is the sync value of the state after the current code group.
// Counters are sized from the thresholds; thresholds must be 1 or more.
`timescale 1ns/1ps

module sync_state_machine #(
    parameter int idle_count = pcs_sync_pkg::default_idle_count,
    parameter int good_run   = pcs_sync_pkg::default_good_run,
    parameter int bad_limit  = pcs_sync_pkg::default_bad_limit
) (
    input  logic          clk,
    input  logic          reset,
    code_group_if.control cg_bus,
    output logic          sync_ok
);

    localparam int idle_w = $clog2(idle_count + 1);
    localparam int good_w = $clog2(good_run + 1);
    localparam int bad_w  = $clog2(bad_limit + 1);

    pcs_sync_pkg::sync_state_t state;
    pcs_sync_pkg::sync_state_t state_next;

    logic [idle_w-1:0] idle_cnt, idle_cnt_next; // Comma+idle pairs seen.
    logic [good_w-1:0] good_cnt, good_cnt_next; // Current run of valid groups.
    logic [bad_w-1:0]  bad_cnt, bad_cnt_next;   // Invalid groups since sync_acquired.

    logic [idle_w-1:0] idle_inc;
    logic [good_w-1:0] good_inc;
    logic [bad_w-1:0]  bad_inc;

    assign idle_inc = idle_cnt + 1'b1;
    assign good_inc = good_cnt + 1'b1;
    assign bad_inc  = bad_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= pcs_sync_pkg::loss_of_sync;
            idle_cnt <= '0;
            good_cnt <= '0;
            bad_cnt  <= '0;
        end else begin
            state    <= state_next;
            idle_cnt <= idle_cnt_next;
            good_cnt <= good_cnt_next;
            bad_cnt  <= bad_cnt_next;
        end
    end

    always_comb begin
        state_next    = state; // Hold by default.
        idle_cnt_next = idle_cnt;
        good_cnt_next = good_cnt;
        bad_cnt_next  = bad_cnt;
        case (state)
            pcs_sync_pkg::loss_of_sync: begin
                if (cg_bus.is_comma) begin
                    state_next = pcs_sync_pkg::comma_detect; // Start of a possible /I/.
                end
            end
            pcs_sync_pkg::comma_detect: begin
                if (cg_bus.is_idle_data) begin
                    if (idle_inc == idle_w'(idle_count)) begin
                        state_next    = pcs_sync_pkg::sync_acquired; // Enough /I/ seen.
                        idle_cnt_next = '0;
                    end else begin
                        state_next    = pcs_sync_pkg::acquire_sync;
                        idle_cnt_next = idle_inc;
                    end
                end else begin
                    state_next    = pcs_sync_pkg::loss_of_sync; // Comma not followed by idle.
                    idle_cnt_next = '0;
                end
            end
            pcs_sync_pkg::acquire_sync: begin
                if (cg_bus.is_comma) begin
                    state_next = pcs_sync_pkg::comma_detect;
                end else if (!cg_bus.is_idle_data) begin
                    state_next    = pcs_sync_pkg::loss_of_sync;
                    idle_cnt_next = '0;
                end
            end
            pcs_sync_pkg::sync_acquired: begin
                if (!cg_bus.is_valid) begin
                    state_next   = pcs_sync_pkg::sync_error; // First error.
                    bad_cnt_next = bad_w'(1);
                end
            end
            pcs_sync_pkg::sync_error,
            pcs_sync_pkg::sync_recover: begin
                if (!cg_bus.is_valid) begin
                    good_cnt_next = '0; // An error breaks the good run.
                    if (bad_inc == bad_w'(bad_limit)) begin
                        state_next   = pcs_sync_pkg::loss_of_sync; // Too many errors.
                        bad_cnt_next = '0;
                    end else begin
                        state_next   = pcs_sync_pkg::sync_error;
                        bad_cnt_next = bad_inc;
                    end
                end else if (state == pcs_sync_pkg::sync_error) begin
                    state_next    = pcs_sync_pkg::sync_recover; // Run starts.
                    good_cnt_next = good_w'(1);
                end else if (good_inc == good_w'(good_run)) begin
                    state_next    = pcs_sync_pkg::sync_acquired; // Full recovery.
                    good_cnt_next = '0;
                    bad_cnt_next  = '0;
                end else begin
                    good_cnt_next = good_inc;
                end
            end
            default: begin
                state_next = pcs_sync_pkg::loss_of_sync;
            end
        endcase
    end

    assign sync_ok = (state_next == pcs_sync_pkg::sync_acquired) ||
                     (state_next == pcs_sync_pkg::sync_error) ||
                     (state_next == pcs_sync_pkg::sync_recover);

    a_bad_cnt_bound: assert property (
        @(posedge clk) disable iff (!reset) bad_cnt <= bad_w'(bad_limit)
    ) else $error("Bad code group count above limit.");

    // Only a comma from the classifier may start acquisition.
    a_leave_loss_on_comma: assert property (
        @(posedge clk) disable iff (!reset)
        (state == pcs_sync_pkg::loss_of_sync && !cg_bus.is_comma)
            |=> (state == pcs_sync_pkg::loss_of_sync)
    ) else $error("Left loss_of_sync without a comma.");

endmodule

// File: tb.f
pcs_sync_pkg.sv
code_group_if.sv
code_group_classifier.sv
sync_state_machine.sv
sudi_formatter.sv
pcs_sync_top.sv
tb_pcs_sync.sv

// File: tb_pcs_sync.sv
// Testbench for the receive synchronizer, driven from sync_cases.txt.
// Each case is rx_cg, expected sudi and expected sync_status in hex.
// A case is checked two clocks after its code group is applied.
// Run from the project root so that the case file is found.
`timescale 1ns/1ps

module tb_pcs_sync;

    localparam int clk_period   = 40; // ns.
    localparam int drive_delay  = 2;  // Inputs change this long after the edge.
    localparam int reset_cycles = 4;
    localparam int latency      = 2;  // rx_cg to sudi, in clocks.

    logic                      clk;
    logic                      reset;
    pcs_sync_pkg::code_group_t rx_cg;
    pcs_sync_pkg::sudi_t       sudi;
    logic                      sync_status;

    pcs_sync_pkg::code_group_t case_cg[$];   // Inputs from the case file.
    pcs_sync_pkg::sudi_t       case_sudi[$]; // Expected SUDI words.
    logic                      case_sync[$]; // Expected sync status.

    int sudi_errors;
    int sync_errors;
    int other_errors;
    bit cases_loaded; // Starts the watchdog.

    pcs_sync_top pcs_sync_top_inst (
        .clk         (clk),
        .reset       (reset),
        .rx_cg       (rx_cg),
        .sudi        (sudi),
        .sync_status (sync_status)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic check_sudi(input string where, input pcs_sync_pkg::sudi_t expected);
        if (sudi !== expected) begin
            sudi_errors++;
            $display("Mismatch sudi at %s: expected 0x%h, actual 0x%h", where, expected, sudi);
        end
    endtask

    task automatic check_sync(input string where, input logic expected);
        if (sync_status !== expected) begin
            sync_errors++;
            $display("Mismatch sync_status at %s: expected 0x%h, actual 0x%h",
                     where, expected, sync_status);
        end
    endtask

    // Reads every case line, skipping comments and blank lines.
    task automatic load_cases();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] cg_val;
        logic [31:0] sudi_val;
        logic [31:0] sync_val;
        fd = $fopen("sync_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the case file sync_cases.txt.");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h", cg_val, sudi_val, sync_val);
                if (fields == 3) begin
                    case_cg.push_back(cg_val[9:0]);
                    case_sudi.push_back(sudi_val[10:0]);
                    case_sync.push_back(sync_val[0]);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int total;
        rx_cg        = '0;
        reset        = 1'b0; // Held low through the first edges.
        sudi_errors  = 0;
        sync_errors  = 0;
        other_errors = 0;
        cases_loaded = 1'b0;
        load_cases();
        if (case_cg.size() == 0 && other_errors == 0) begin
            other_errors++;
            $display("The case file sync_cases.txt holds no cases.");
        end
        total        = case_cg.size();
        cases_loaded = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        check_sudi("reset", '0); // Outputs still in reset.
        check_sync("reset", 1'b0);
        reset = 1'b1;

        // Check the case from two clocks back, then drive the next one.
        for (int i = 0; i < total + latency; i++) begin
            if (i >= latency) begin
                check_sudi($sformatf("case %0d", i - latency), case_sudi[i - latency]);
                check_sync($sformatf("case %0d", i - latency), case_sync[i - latency]);
            end
            if (i < total) begin
                rx_cg = case_cg[i];
            end
            @(posedge clk);
            #drive_delay;
        end

        $display("Errors: sudi %0d, sync_status %0d, other %0d",
                 sudi_errors, sync_errors, other_errors);
        if (sudi_errors + sync_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Limit is the case count plus margin for reset and pipeline drain.
    initial begin
        wait (cases_loaded);
        #((case_cg.size() + 10) * clk_period);
        $display("Timeout: the run did not finish within %0d clock cycles.",
                 case_cg.size() + 10);
        $display("Result: FAILED");
        $finish;
    end

endmodule
